// File: verilog.f
+incdir+sim
src/float_pkg.sv
src/float_unpack.sv
src/mantissa_mul.sv
src/float_normalize.sv
src/float_mul_ctrl.sv
src/float_mul_pipeline.sv
sim/float_mul_tb.sv

// File: Bender.yml
package:
  name: float_mul_pipeline

sources:
  - files:
      - src/float_pkg.sv
      - src/float_unpack.sv
      - src/mantissa_mul.sv
      - src/float_normalize.sv
      - src/float_mul_ctrl.sv
      - src/float_mul_pipeline.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/float_mul_tb.sv

// File: sim/float_mul_model.svh
`ifndef FLOAT_MUL_MODEL_SVH
`define FLOAT_MUL_MODEL_SVH

// single precision word from a real, extra fraction bits dropped
function automatic logic [31:0] real_to_float(input real r);
    logic [63:0]       d;
    int                e;
    float_pkg::float_t f;
    d = $realtobits(r);
    e = int'(d[62:52]) - 1023 + float_pkg::exp_bias;
    f.bits = '0;
    f.fields.sign = d[63];
    if (d[62:52] != 11'd0 && e > 0) begin
        f.fields.exp  = e[7:0];
        f.fields.frac = d[51:29];
    end
    return f.bits;
endfunction

// reference product, truncated, with saturation and flush to zero
function automatic logic [31:0] expected_mul(input logic [31:0] x, input logic [31:0] y);
    float_pkg::float_t fx;
    float_pkg::float_t fy;
    float_pkg::float_t r;
    logic [47:0]       p;
    logic [22:0]       frac;
    int                e;
    fx = x;
    fy = y;
    r.bits = '0;
    r.fields.sign = fx.fields.sign ^ fy.fields.sign;
    if (fx.fields.exp == 8'd0 || fy.fields.exp == 8'd0) begin
        return r.bits;
    end
    p = {24'd0, 1'b1, fx.fields.frac} * {24'd0, 1'b1, fy.fields.frac};
    e = int'(fx.fields.exp) + int'(fy.fields.exp) - float_pkg::exp_bias;
    if (p[47]) begin
        frac = p[46:24];
        e = e + 1;
    end else begin
        frac = p[45:23];
    end
    if (e >= 255) begin
        r.fields.exp  = 8'hfe;
        r.fields.frac = '1;
    end else if (e > 0) begin
        r.fields.exp  = e[7:0];
        r.fields.frac = frac;
    end
    return r.bits;
endfunction

`endif

// File: sim/float_mul_tb.sv
`timescale 1ns/1ps

module float_mul_tb;

    localparam int clk_period  = 40;
    localparam int ack_limit   = 40;
    localparam int max_latency = 30;
    // operations over all tests, rounded up
    localparam int num_ops         = 70;
    localparam int watchdog_cycles = num_ops * ack_limit + 200;

    logic        clk;
    logic        rst_n;
    logic        req;
    logic [31:0] a;
    logic [31:0] b;
    logic        ack;
    logic [31:0] out;

    int          errors = 0;
    int          checks = 0;
    int          tests  = 0;
    logic [31:0] lcg_state = 32'hbe76_1723;

    `include "float_mul_model.svh"

    float_mul_pipeline #(
        .bits_per_cycle (2)
    ) DUT (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .a     (a),
        .b     (b),
        .ack   (ack),
        .out   (out)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("watchdog expired after %0d cycles, tests did not complete", watchdog_cycles);
        $display("sim failed");
        $finish;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // exponent field kept in 100..150 so products stay finite
    function automatic logic [31:0] random_operand();
        logic [31:0] r1;
        logic [31:0] r2;
        r1 = lcg_next();
        r2 = lcg_next();
        return {r1[31], 8'(100 + r1[23:16] % 51), r2[31:9]};
    endfunction

    task automatic drive_req(input logic [31:0] x, input logic [31:0] y);
        @(posedge clk);
        a   <= x;
        b   <= y;
        req <= 1'b1;
        @(posedge clk);
        req <= 1'b0;
    endtask

    // lat counts cycles from the edge that samples req
    task automatic wait_ack(output int lat, output logic [31:0] res, output bit seen);
        lat  = 0;
        seen = 1'b0;
        res  = '0;
        while (!seen && lat < ack_limit) begin
            @(negedge clk);
            lat++;
            if (ack) begin
                seen = 1'b1;
                res  = out;
            end
        end
    endtask

    task automatic run_op(input string name, input logic [31:0] x, input logic [31:0] y,
                          output logic [31:0] res, output int lat);
        logic [31:0] want;
        bit          seen;
        drive_req(x, y);
        wait_ack(lat, res, seen);
        if (!seen) begin
            $display("%s: DUT gave no ack within %0d cycles for %h x %h", name, ack_limit, x, y);
            errors++;
            return;
        end
        want = expected_mul(x, y);
        checks++;
        assert (res == want) else begin
            $display("FAIL %0t %s: %h x %h gave %h, expected %h", $time, name, x, y, res, want);
            errors++;
        end
        checks++;
        assert (lat <= max_latency) else begin
            $display("FAIL %0t %s: ack after %0d cycles", $time, name, lat);
            errors++;
        end
        @(negedge clk);
        checks++;
        assert (!ack) else begin
            $display("FAIL %0t %s: ack longer than one cycle", $time, name);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    task automatic zero_op(input logic [31:0] x, input logic [31:0] y);
        logic [31:0] res;
        int          lat;
        run_op("zero_path", x, y, res, lat);
        // ack only in the cycle after edge 2
        checks++;
        assert (lat == 3) else begin
            $display("FAIL %0t zero_path: ack after %0d cycles, expected 3", $time, lat);
            errors++;
        end
    endtask

    task automatic test_zero_path();
        int e0;
        e0 = errors;
        zero_op(real_to_float(0.0), real_to_float(1.0));
        zero_op(real_to_float(1.0), real_to_float(0.0));
        zero_op(real_to_float(0.0), real_to_float(0.0));
        zero_op(32'h8000_0000, real_to_float(3.0));
        report_test("zero_path", e0);
    endtask

    task automatic test_exact();
        logic [31:0] res;
        int          lat;
        int          e0;
        e0 = errors;
        run_op("exact", real_to_float(1.0), real_to_float(1.0), res, lat);
        run_op("exact", real_to_float(2.0), real_to_float(2.0), res, lat);
        run_op("exact", real_to_float(8.0), real_to_float(4.0), res, lat);
        run_op("exact", real_to_float(10.0), real_to_float(4.0), res, lat);
        run_op("exact", real_to_float(200.0), real_to_float(100.0), res, lat);
        run_op("exact", real_to_float(101.0), real_to_float(4.0), res, lat);
        report_test("exact", e0);
    endtask

    task automatic test_signs();
        logic [31:0] res;
        int          lat;
        int          e0;
        e0 = errors;
        run_op("signs", real_to_float(-2000.0), real_to_float(2.3), res, lat);
        run_op("signs", real_to_float(2000.0), real_to_float(-2.3), res, lat);
        run_op("signs", real_to_float(-2000.0), real_to_float(-2.3), res, lat);
        report_test("signs", e0);
    endtask

    task automatic test_truncation();
        logic [31:0] res;
        int          lat;
        int          e0;
        e0 = errors;
        run_op("truncation", real_to_float(1.1), real_to_float(1.1), res, lat);
        run_op("truncation", real_to_float(1.9), real_to_float(1.9), res, lat);
        run_op("truncation", real_to_float(2.0), real_to_float(2.3), res, lat);
        for (int i = 0; i < 50; i++) begin
            run_op("truncation", random_operand(), random_operand(), res, lat);
        end
        report_test("truncation", e0);
    endtask

    task automatic test_range();
        logic [31:0] res;
        int          lat;
        int          e0;
        e0 = errors;
        run_op("range", {1'b0, 8'd250, 23'd0}, {1'b0, 8'd250, 23'h40_0000}, res, lat);
        checks++;
        assert (res == 32'h7f7f_ffff) else begin
            $display("FAIL %0t range: overflow gave %h, expected 7f7fffff", $time, res);
            errors++;
        end
        run_op("range", {1'b1, 8'd10, 23'h12_3456}, {1'b0, 8'd10, 23'd0}, res, lat);
        checks++;
        assert (res == 32'h8000_0000) else begin
            $display("FAIL %0t range: underflow gave %h, expected 80000000", $time, res);
            errors++;
        end
        report_test("range", e0);
    endtask

    task automatic test_busy_req();
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] res;
        logic [31:0] want;
        int          lat;
        int          extra;
        bit          seen;
        int          e0;
        e0 = errors;
        x = real_to_float(3.0);
        y = real_to_float(5.0);
        drive_req(x, y);
        // second request lands while the multiplier runs
        repeat (2) @(posedge clk);
        drive_req(real_to_float(7.0), real_to_float(9.0));
        wait_ack(lat, res, seen);
        if (!seen) begin
            $display("busy_req: DUT gave no ack for the first request");
            errors++;
        end else begin
            want = expected_mul(x, y);
            checks++;
            assert (res == want) else begin
                $display("FAIL %0t busy_req: got %h, expected %h", $time, res, want);
                errors++;
            end
        end
        extra = 0;
        repeat (ack_limit) begin
            @(negedge clk);
            if (ack) begin
                extra++;
            end
        end
        checks++;
        assert (extra == 0) else begin
            $display("FAIL %0t busy_req: %0d extra ack pulses", $time, extra);
            errors++;
        end
        report_test("busy_req", e0);
    endtask

    initial begin
        rst_n = 1'b0;
        req   = 1'b0;
        a     = '0;
        b     = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        checks++;
        assert (!ack && out == '0) else begin
            $display("FAIL %0t reset: ack %b out %h", $time, ack, out);
            errors++;
        end
        test_zero_path();
        test_exact();
        test_signs();
        test_truncation();
        test_range();
        test_busy_req();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: src/float_mul_pipeline.sv
`timescale 1ns/1ps

module float_mul_pipeline #(
    parameter int bits_per_cycle = 1
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               req,
    input  logic [float_pkg::float_width-1:0]  a,
    input  logic [float_pkg::float_width-1:0]  b,
    output logic                               ack,
    output logic [float_pkg::float_width-1:0]  out
);

    // control strobes
    logic load;
    logic start;
    logic finish;
    logic zero_result;
    logic mul_done;

    // unpacked operand fields
    logic                                   sign_p;
    logic signed [float_pkg::exp_width+1:0] exp_sum;
    logic [float_pkg::mant_width-1:0]       mant_a;
    logic [float_pkg::mant_width-1:0]       mant_b;
    logic                                   is_zero;

    logic [2*float_pkg::mant_width-1:0]     product;

    float_unpack u_unpack (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (load),
        .a       (a),
        .b       (b),
        .sign_p  (sign_p),
        .exp_sum (exp_sum),
        .mant_a  (mant_a),
        .mant_b  (mant_b),
        .is_zero (is_zero)
    );

    float_mul_ctrl #(
        .bits_per_cycle (bits_per_cycle)
    ) u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .is_zero     (is_zero),
        .mul_done    (mul_done),
        .load        (load),
        .start       (start),
        .finish      (finish),
        .zero_result (zero_result),
        .ack         (ack)
    );

    mantissa_mul #(
        .bits_per_cycle (bits_per_cycle)
    ) u_mul (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .mant_a   (mant_a),
        .mant_b   (mant_b),
        .mul_done (mul_done),
        .product  (product)
    );

    float_normalize u_norm (
        .clk         (clk),
        .rst_n       (rst_n),
        .finish      (finish),
        .zero_result (zero_result),
        .sign_p      (sign_p),
        .exp_sum     (exp_sum),
        .product     (product),
        .out         (out)
    );

endmodule

// File: src/float_mul_ctrl.sv
`timescale 1ns/1ps

module float_mul_ctrl #(
    parameter int bits_per_cycle = 1
) (
    input  logic clk,
    input  logic rst_n,
    input  logic req,
    input  logic is_zero,
    input  logic mul_done,
    output logic load,
    output logic start,
    output logic finish,
    output logic zero_result,
    output logic ack
);

    // give up on the multiplier a few cycles past its nominal run
    localparam int iterations = float_pkg::mant_width / bits_per_cycle;
    localparam int timeout    = iterations + 4;
    localparam int tmo_width  = $clog2(timeout + 1);

    localparam logic [2:0] st_idle      = 3'd0;
    localparam logic [2:0] st_decide    = 3'd1;
    localparam logic [2:0] st_multiply  = 3'd2;
    localparam logic [2:0] st_normalize = 3'd3;
    localparam logic [2:0] st_respond   = 3'd4;

    logic [2:0]           state;
    logic [tmo_width-1:0] wait_cnt;
    logic                 start_q;
    logic                 zero_q;

    // operands captured on the same edge that sees req
    assign load        = req && (state == st_idle);
    assign start       = start_q;
    assign finish      = (state == st_normalize);
    assign zero_result = zero_q;
    assign ack         = (state == st_respond);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= st_idle;
            wait_cnt <= '0;
            start_q  <= 1'b0;
            zero_q   <= 1'b0;
        end else begin
            start_q <= 1'b0;
            case (state)
                st_idle: begin
                    if (req) begin
                        state <= st_decide;
                    end
                end
                // unpacked flags are valid here
                st_decide: begin
                    zero_q   <= is_zero;
                    wait_cnt <= '0;
                    if (is_zero) begin
                        state <= st_normalize;
                    end else begin
                        state   <= st_multiply;
                        start_q <= 1'b1;
                    end
                end
                st_multiply: begin
                    if (mul_done) begin
                        state <= st_normalize;
                    end else if (wait_cnt == tmo_width'(timeout)) begin
                        // multiplier stuck, drop the request
                        state <= st_idle;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                st_normalize: state <= st_respond;
                st_respond:   state <= st_idle;
                default:      state <= st_idle;
            endcase
        end
    end

endmodule

// File: src/float_normalize.sv
`timescale 1ns/1ps

module float_normalize (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    finish,
    input  logic                                    zero_result,
    input  logic                                    sign_p,
    input  logic signed [float_pkg::exp_width+1:0]  exp_sum,
    input  logic [2*float_pkg::mant_width-1:0]      product,
    output logic [float_pkg::float_width-1:0]       out
);

    localparam int prod_msb = 2 * float_pkg::mant_width - 1;
    localparam int exp_max  = (1 << float_pkg::exp_width) - 1;

    logic signed [float_pkg::exp_width+1:0] exp_adj;
    logic [float_pkg::frac_width-1:0]       frac_sel;
    float_pkg::float_t                      result;

    // product is in [1, 4), so the leading one is bit 47 or bit 46
    always_comb begin
        if (product[prod_msb]) begin
            frac_sel = product[prod_msb-1 -: float_pkg::frac_width];
            exp_adj  = exp_sum + (float_pkg::exp_width + 2)'(1);
        end else begin
            frac_sel = product[prod_msb-2 -: float_pkg::frac_width];
            exp_adj  = exp_sum;
        end
    end

    // range checks and packing, truncation only
    always_comb begin
        result.fields.sign = sign_p;
        if (zero_result || exp_adj <= 0) begin
            result.fields.exp  = '0;
            result.fields.frac = '0;
        end else if (exp_adj >= exp_max) begin
            // largest finite value
            result.fields.exp  = {{(float_pkg::exp_width-1){1'b1}}, 1'b0};
            result.fields.frac = '1;
        end else begin
            result.fields.exp  = exp_adj[float_pkg::exp_width-1:0];
            result.fields.frac = frac_sel;
        end
    end

    // result register, held until the next finish
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out <= '0;
        end else if (finish) begin
            out <= result.bits;
        end
    end

endmodule

// File: src/mantissa_mul.sv
`timescale 1ns/1ps

module mantissa_mul #(
    parameter int bits_per_cycle = 1
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                start,
    input  logic [float_pkg::mant_width-1:0]    mant_a,
    input  logic [float_pkg::mant_width-1:0]    mant_b,
    output logic                                mul_done,
    output logic [2*float_pkg::mant_width-1:0]  product
);

    localparam int prod_width = 2 * float_pkg::mant_width;
    localparam int iterations = float_pkg::mant_width / bits_per_cycle;
    localparam int cnt_width  = $clog2(iterations + 1);

    logic                                busy;
    logic [cnt_width-1:0]                count;
    logic [prod_width-1:0]               mcand;
    logic [float_pkg::mant_width-1:0]    mplier;
    logic [prod_width-1:0]               acc;
    logic [prod_width-1:0]               partial;

    // sum of the partial products for the low multiplier bits
    always_comb begin
        partial = '0;
        for (int i = 0; i < bits_per_cycle; i++) begin
            if (mplier[i]) begin
                partial = partial + (mcand << i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            count    <= '0;
            mul_done <= 1'b0;
        end else begin
            mul_done <= 1'b0;
            if (start) begin
                busy  <= 1'b1;
                count <= cnt_width'(iterations);
            end else if (busy) begin
                count <= count - 1'b1;
                // last step, acc is final after this edge
                if (count == cnt_width'(1)) begin
                    busy     <= 1'b0;
                    mul_done <= 1'b1;
                end
            end
        end
    end

    // datapath, cleared on every start
    always_ff @(posedge clk) begin
        if (start) begin
            mcand  <= {{float_pkg::mant_width{1'b0}}, mant_a};
            mplier <= mant_b;
            acc    <= '0;
        end else if (busy) begin
            acc    <= acc + partial;
            mcand  <= mcand << bits_per_cycle;
            mplier <= mplier >> bits_per_cycle;
        end
    end

    // acc stays put once busy drops
    assign product = acc;

endmodule

// File: src/float_unpack.sv
`timescale 1ns/1ps

module float_unpack (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                load,
    input  logic [float_pkg::float_width-1:0]   a,
    input  logic [float_pkg::float_width-1:0]   b,
    output logic                                sign_p,
    output logic signed [float_pkg::exp_width+1:0] exp_sum,
    output logic [float_pkg::mant_width-1:0]    mant_a,
    output logic [float_pkg::mant_width-1:0]    mant_b,
    output logic                                is_zero
);

    float_pkg::float_t fa;
    float_pkg::float_t fb;

    logic signed [float_pkg::exp_width+1:0] exp_a_ext;
    logic signed [float_pkg::exp_width+1:0] exp_b_ext;
    logic signed [float_pkg::exp_width+1:0] bias_ext;

    assign fa = a;
    assign fb = b;

    // two guard bits keep the sum and the negative range
    assign exp_a_ext = {2'b00, fa.fields.exp};
    assign exp_b_ext = {2'b00, fb.fields.exp};
    assign bias_ext  = (float_pkg::exp_width + 2)'(float_pkg::exp_bias);

    // zero flag steers the controller
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            is_zero <= 1'b0;
        end else if (load) begin
            // denormals fall in here too
            is_zero <= (fa.fields.exp == '0) || (fb.fields.exp == '0);
        end
    end

    // operand fields, held until the next accepted request
    always_ff @(posedge clk) begin
        if (load) begin
            sign_p  <= fa.fields.sign ^ fb.fields.sign;
            exp_sum <= exp_a_ext + exp_b_ext - bias_ext;
            mant_a  <= {1'b1, fa.fields.frac};
            mant_b  <= {1'b1, fb.fields.frac};
        end
    end

endmodule

// File: src/float_pkg.sv
package float_pkg;

    // ieee 754 single precision layout
    localparam int float_width = 32;
    localparam int exp_width   = 8;
    localparam int frac_width  = 23;

    // fraction plus the hidden leading one
    localparam int mant_width  = frac_width + 1;

    localparam int exp_bias    = 127;

    // one float word, read either as raw bits or as its fields
    typedef union packed {
        logic [float_width-1:0] bits;
        struct packed {
            logic                  sign;
            logic [exp_width-1:0]  exp;
            logic [frac_width-1:0] frac;
        } fields;
    } float_t;

endpackage
